// File: Makefile
# Verilator build and run for the M90 system-control slice

VERILATOR ?= verilator
TOP       ?= tb_m90_sys
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Something failed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
m90_sys_pkg.sv
m90_pause_ctrl.sv
m90_cpu_clock.sv
m90_sys_regs.sv
m90_input_ports.sv
m90_sys_ctrl.sv
m90_sys_properties.sv
tb_m90_sys_checker.sv
tb_m90_sys.sv

// File: m90_cpu_clock.sv
/* 18 MHz enable from a 9/20 accumulator, split into two processor phases.
   Enables lost while rom_ready is low are banked and replayed at full rate. */
`timescale 1ns/1ps

module m90_cpu_clock (
    input  logic                            clk_sys,
    input  logic                            reset_n,
    input  logic                            cpu_paused,
    input  logic                            turbo,
    input  logic                            rom_ready,
    output logic                            ce_1,
    output logic                            ce_2,
    output logic [m90_sys_pkg::timer_w-1:0] cycle_count
);

    logic [m90_sys_pkg::phase_w-1:0]    phase_acc;
    logic [m90_sys_pkg::phase_w-1:0]    phase_sum;
    logic                               ce_18m;
    logic [m90_sys_pkg::deferred_w-1:0] deferred_ce;
    logic                               ce_toggle;
    logic                               ce_1_q;
    logic                               ce_2_q;
    logic                               step;

    // ========================================================================
    // Fractional enable
    // ========================================================================
    assign phase_sum = phase_acc + m90_sys_pkg::cen_num;
    assign ce_18m    = (phase_sum >= m90_sys_pkg::cen_den);

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            phase_acc <= '0;
        end else begin
            phase_acc <= ce_18m ? phase_sum - m90_sys_pkg::cen_den : phase_sum;
        end
    end

    // ========================================================================
    // Deferral bank and phase toggle
    // ========================================================================
    assign step = !cpu_paused && (ce_18m || turbo || (rom_ready && |deferred_ce));

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            deferred_ce <= '0;
            ce_toggle   <= 1'b0;
            ce_1_q      <= 1'b0;
            ce_2_q      <= 1'b0;
        end else begin
            if (ce_18m) begin
                if (!rom_ready) begin
                    if (!(&deferred_ce)) deferred_ce <= deferred_ce + 1'b1;
                end else if (|deferred_ce) begin
                    deferred_ce <= deferred_ce - 1'b1;
                end
            end

            ce_1_q <= 1'b0;
            ce_2_q <= 1'b0;
            if (step) begin
                ce_toggle <= ~ce_toggle;
                ce_1_q    <= ce_toggle;
                ce_2_q    <= ~ce_toggle;
            end
        end
    end

    // Stalled or paused processor sees no phase at all
    assign ce_1 = ce_1_q && rom_ready && !cpu_paused;
    assign ce_2 = ce_2_q && rom_ready && !cpu_paused;

    // Free-running processor cycle timer
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            cycle_count <= '0;
        end else if (ce_1) begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

endmodule

// File: m90_input_ports.sv
/* Input-port read map for standard and kick harness wirings.
   Switches and DIPs are active low on the bus; rdata is idle unless io_rd is high. */
`timescale 1ns/1ps

module m90_input_ports (
    input  m90_sys_pkg::cpu_bus_t   bus,
    input  m90_sys_pkg::board_cfg_t board_cfg,
    input  m90_sys_pkg::player_in_t players,
    input  logic [23:0]             dip_sw,
    input  logic                    dma_busy,
    input  logic [7:0]              snd_latch,
    output logic [15:0]             rdata
);

    logic [7:0]  sw_p1;
    logic [7:0]  sw_p2;
    logic [7:0]  sw_p3;
    logic [7:0]  sw_p4;
    logic [15:0] flags;

    // ========================================================================
    // Switch bytes per harness
    // ========================================================================
    always_comb begin
        if (board_cfg.kick_harness) begin
            // Kick button rides on bit 5, extra buttons move to the player 4 byte
            sw_p1 = {players.p1[4], players.p1[5], players.p1[6], 1'b0, players.p1[3:0]};
            sw_p2 = {players.p2[4], players.p2[5], players.p2[6], 1'b0, players.p2[3:0]};
            sw_p3 = 8'h00;
            sw_p4 = {players.p2[9], players.p2[8], players.p2[7], 1'b0,
                     players.p1[9], players.p1[8], players.p1[7], 1'b0};
        end else begin
            sw_p1 = {players.p1[4], players.p1[5], 2'b00, players.p1[3:0]};
            sw_p2 = {players.p2[4], players.p2[5], 2'b00, players.p2[3:0]};
            sw_p3 = {players.p3[4], players.p3[5], players.coin[2], players.start[2],
                     players.p3[3:0]};
            sw_p4 = {players.p4[4], players.p4[5], players.coin[3], players.start[3],
                     players.p4[3:0]};
        end
    end

    // Test and service inputs read as released
    assign flags = {~dip_sw[23:16], ~dma_busy, 3'b111,
                    ~players.coin[1:0], ~players.start[1:0]};

    // ========================================================================
    // Read mux
    // ========================================================================
    always_comb begin
        rdata = m90_sys_pkg::io_idle;
        if (bus.io_rd) begin
            case (bus.word_addr)
                m90_sys_pkg::io_p1_p2: rdata = {~sw_p2, ~sw_p1};
                m90_sys_pkg::io_flags: rdata = flags;
                m90_sys_pkg::io_dip:   rdata = ~dip_sw[15:0];
                m90_sys_pkg::io_p3_p4: rdata = {~sw_p4, ~sw_p3};
                m90_sys_pkg::io_latch: rdata = {snd_latch, snd_latch};
                default:               rdata = m90_sys_pkg::io_idle;
            endcase
        end
    end

endmodule

// File: m90_pause_ctrl.sv
/* Pause takes effect only at a vertical pulse, so a frame is never split.
   cpu_paused follows the state register, one cycle after the deciding vpulse. */
`timescale 1ns/1ps

module m90_pause_ctrl (
    input  logic clk_sys,
    input  logic reset_n,
    input  logic pause_rq,
    input  logic vpulse,
    output logic cpu_paused
);

    m90_sys_pkg::pause_state_t state;

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            state <= m90_sys_pkg::run;
        end else begin
            case (state)
                m90_sys_pkg::run: begin
                    if (pause_rq) state <= m90_sys_pkg::wait_vbl;
                end
                m90_sys_pkg::wait_vbl: begin
                    // Request withdrawn before the frame ended
                    if (!pause_rq) state <= m90_sys_pkg::run;
                    else if (vpulse) state <= m90_sys_pkg::paused;
                end
                m90_sys_pkg::paused: begin
                    if (!pause_rq && !vpulse) state <= m90_sys_pkg::run;
                end
                default: state <= m90_sys_pkg::run;
            endcase
        end
    end

    assign cpu_paused = (state == m90_sys_pkg::paused);

endmodule

// File: m90_sys_ctrl.sv
/* System-control slice top: pause, processor clock enables, system registers
   and input ports. The processor itself lives outside. */
`timescale 1ns/1ps

module m90_sys_ctrl (
    input  logic                            clk_sys,
    input  logic                            reset_n,
    input  m90_sys_pkg::cpu_bus_t           bus,
    input  logic                            rom_ready,
    input  logic                            vpulse,
    input  logic                            pause_rq,
    input  logic                            turbo,
    input  m90_sys_pkg::board_cfg_t         board_cfg,
    input  m90_sys_pkg::player_in_t         players,
    input  logic [23:0]                     dip_sw,
    input  logic                            dma_busy,
    input  logic [7:0]                      snd_latch,
    output logic                            ce_1,
    output logic                            ce_2,
    output logic [m90_sys_pkg::timer_w-1:0] cycle_count,
    output m90_sys_pkg::sys_flags_t         sys_flags,
    output logic                            flip,
    output logic [3:0]                      bank_select,
    output logic                            sound_reset,
    output logic [15:0]                     rdata
);

    logic cpu_paused;

    m90_pause_ctrl u_pause_ctrl (
        .clk_sys    (clk_sys),
        .reset_n    (reset_n),
        .pause_rq   (pause_rq),
        .vpulse     (vpulse),
        .cpu_paused (cpu_paused)
    );

    m90_cpu_clock u_cpu_clock (
        .clk_sys     (clk_sys),
        .reset_n     (reset_n),
        .cpu_paused  (cpu_paused),
        .turbo       (turbo),
        .rom_ready   (rom_ready),
        .ce_1        (ce_1),
        .ce_2        (ce_2),
        .cycle_count (cycle_count)
    );

    // DIP bit 8 is the flip switch
    m90_sys_regs u_sys_regs (
        .clk_sys     (clk_sys),
        .reset_n     (reset_n),
        .bus         (bus),
        .dip_nl      (dip_sw[8]),
        .sys_flags   (sys_flags),
        .flip        (flip),
        .bank_select (bank_select),
        .sound_reset (sound_reset)
    );

    m90_input_ports u_input_ports (
        .bus       (bus),
        .board_cfg (board_cfg),
        .players   (players),
        .dip_sw    (dip_sw),
        .dma_busy  (dma_busy),
        .snd_latch (snd_latch),
        .rdata     (rdata)
    );

endmodule

// File: m90_sys_pkg.sv
/* Shared types and constants for the M90 system-control slice.
   The processor bus arrives as single-cycle io_wr/io_rd strobes with word addresses. */

package m90_sys_pkg;

    // ========================================================================
    // Clock enable and counter sizing
    // ========================================================================
    localparam int phase_w    = 5;
    localparam logic [phase_w-1:0] cen_num = 5'd9;
    localparam logic [phase_w-1:0] cen_den = 5'd20;
    localparam int deferred_w = 16;
    localparam int timer_w    = 16;

    // ========================================================================
    // I/O port map
    // ========================================================================
    // Write ports
    localparam logic [7:0] io_sys_flags = 8'h02;
    localparam logic [7:0] io_bank      = 8'h20;
    localparam logic [7:0] io_sound     = 8'hc0;

    // Read ports
    localparam logic [7:0] io_p1_p2 = 8'h00;
    localparam logic [7:0] io_flags = 8'h02;
    localparam logic [7:0] io_dip   = 8'h04;
    localparam logic [7:0] io_p3_p4 = 8'h06;
    localparam logic [7:0] io_latch = 8'h08;

    localparam logic [15:0] io_idle = 16'hffff;

    typedef struct packed {
        logic        io_wr;
        logic        io_rd;
        logic [7:0]  word_addr;
        logic [15:0] wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic [9:0] p1;
        logic [9:0] p2;
        logic [9:0] p3;
        logic [9:0] p4;
        logic [3:0] coin;
        logic [3:0] start;
    } player_in_t;

    typedef struct packed {
        logic kick_harness;
        logic reserved;
    } board_cfg_t;

    // Bit 0 is coin0, matching the data bus layout of the flag port
    typedef struct packed {
        logic [1:0] spare;
        logic       bank;
        logic       brq_n;
        logic       cblk;
        logic       soft_nl_n;
        logic       coin1;
        logic       coin0;
    } sys_flags_t;

    typedef enum logic [1:0] {
        run      = 2'd0,
        wait_vbl = 2'd1,
        paused   = 2'd2
    } pause_state_t;

endpackage

// File: m90_sys_properties.sv
/* Phase-enable checks, bound into m90_cpu_clock. Disabled while reset_n is low. */
`timescale 1ns/1ps

module m90_sys_properties (
    input logic clk_sys,
    input logic reset_n,
    input logic ce_1,
    input logic ce_2,
    input logic cpu_paused,
    input logic rom_ready
);

    // The two processor phases never overlap
    phase_exclusive: assert property (@(posedge clk_sys) disable iff (!reset_n)
        !(ce_1 && ce_2))
        else $error("ce_1 and ce_2 are high in the same cycle");

    no_phase_while_paused: assert property (@(posedge clk_sys) disable iff (!reset_n)
        cpu_paused |-> !(ce_1 || ce_2))
        else $error("phase enable is high while the processor is paused");

    // A stalled ROM fetch must hold the processor
    no_phase_while_stalled: assert property (@(posedge clk_sys) disable iff (!reset_n)
        !rom_ready |-> !(ce_1 || ce_2))
        else $error("phase enable is high while rom_ready is low");

endmodule

// File: m90_sys_regs.sv
/* Write-only system registers, updated one cycle after a matching io_wr.
   Only the low byte of the data bus is decoded. */
`timescale 1ns/1ps

module m90_sys_regs (
    input  logic                    clk_sys,
    input  logic                    reset_n,
    input  m90_sys_pkg::cpu_bus_t   bus,
    input  logic                    dip_nl,
    output m90_sys_pkg::sys_flags_t sys_flags,
    output logic                    flip,
    output logic [3:0]              bank_select,
    output logic                    sound_reset
);

    logic wr_flags;
    logic wr_bank;
    logic wr_sound;

    assign wr_flags = bus.io_wr && (bus.word_addr == m90_sys_pkg::io_sys_flags);
    assign wr_bank  = bus.io_wr && (bus.word_addr == m90_sys_pkg::io_bank);
    assign wr_sound = bus.io_wr && (bus.word_addr == m90_sys_pkg::io_sound);

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            sys_flags   <= '0;
            bank_select <= 4'd0;
            sound_reset <= 1'b0;
        end else begin
            if (wr_flags) begin
                sys_flags <= m90_sys_pkg::sys_flags_t'(bus.wdata[7:0]);
            end
            if (wr_bank) begin
                bank_select <= bus.wdata[3:0];
            end
            // Sound CPU is held in reset while bit 0 is low
            if (wr_sound) begin
                sound_reset <= ~bus.wdata[0];
            end
        end
    end

    // Screen flip combines the software bit with the flip switch
    assign flip = ~sys_flags.soft_nl_n ^ ~dip_nl;

endmodule

// File: tb_m90_sys.sv
/* Seeded random stimulus in four 1000-cycle phases with inputs changing on the rising edge.
   Phases add ROM stalls, then pause requests, then everything together. */
`timescale 1ns/1ps

module tb_m90_sys;

    localparam int clk_period     = 40;
    localparam int reset_cycles   = 8;
    localparam int phase_cycles   = 1000;
    localparam int num_phases     = 4;
    localparam int timeout_cycles = (num_phases + 1) * phase_cycles;

    logic                            clk_sys;
    logic                            reset_n;
    m90_sys_pkg::cpu_bus_t           bus;
    logic                            rom_ready;
    logic                            vpulse;
    logic                            pause_rq;
    logic                            turbo;
    m90_sys_pkg::board_cfg_t         board_cfg;
    m90_sys_pkg::player_in_t         players;
    logic [23:0]                     dip_sw;
    logic                            dma_busy;
    logic [7:0]                      snd_latch;
    logic                            ce_1;
    logic                            ce_2;
    logic [m90_sys_pkg::timer_w-1:0] cycle_count;
    m90_sys_pkg::sys_flags_t         sys_flags;
    logic                            flip;
    logic [3:0]                      bank_select;
    logic                            sound_reset;
    logic [15:0]                     rdata;
    int                              error_count;
    int                              check_count;
    integer                          seed;
    int                              stall_left;
    int                              pause_left;
    int                              watchdog = 0;

    m90_sys_ctrl DUT (.*);

    tb_m90_sys_checker u_checker (.*);

    bind m90_cpu_clock m90_sys_properties u_properties (
        .clk_sys    (clk_sys),
        .reset_n    (reset_n),
        .ce_1       (ce_1),
        .ce_2       (ce_2),
        .cpu_paused (cpu_paused),
        .rom_ready  (rom_ready)
    );

    initial begin
        clk_sys = 1'b0;
        forever #(clk_period / 2) clk_sys = ~clk_sys;
    end

    task automatic update_controls(input int phase);
        logic [31:0] r;
        r = $random(seed);
        if (r[4:0] == 5'd0) turbo <= ~turbo;
        if (phase == 1 || phase == 3) begin
            if (stall_left == 0) begin
                rom_ready <= ~rom_ready;
                // Low stretches bank enables and high stretches let them replay
                stall_left = rom_ready ? 1 + int'(r[9:5]) : 8 + int'(r[11:5]);
            end else begin
                stall_left = stall_left - 1;
            end
        end else begin
            rom_ready <= 1'b1;
        end
        if (phase >= 2) begin
            if (pause_left == 0) begin
                pause_rq   <= ~pause_rq;
                pause_left = 20 + int'(r[19:13]);
            end else begin
                pause_left = pause_left - 1;
            end
            vpulse <= (r[25:20] == 6'd0);
        end else begin
            pause_rq <= 1'b0;
            vpulse   <= 1'b0;
        end
    endtask

    task automatic randomize_data_inputs();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        players   <= {r0[15:0], r1};
        snd_latch <= r0[23:16];
        dip_sw    <= r2[23:0];
        dma_busy  <= r2[24];
        board_cfg <= m90_sys_pkg::board_cfg_t'(r2[26:25]);
    endtask

    task automatic issue_bus_access(input int phase);
        logic [31:0]           r;
        m90_sys_pkg::cpu_bus_t b;
        r = $random(seed);
        case (r[2:0])
            3'd0:    b.word_addr = m90_sys_pkg::io_sys_flags;
            3'd1:    b.word_addr = m90_sys_pkg::io_bank;
            3'd2:    b.word_addr = m90_sys_pkg::io_sound;
            3'd3:    b.word_addr = m90_sys_pkg::io_p1_p2;
            3'd4:    b.word_addr = m90_sys_pkg::io_dip;
            3'd5:    b.word_addr = m90_sys_pkg::io_p3_p4;
            3'd6:    b.word_addr = m90_sys_pkg::io_latch;
            default: b.word_addr = {r[9:3], 1'b0};
        endcase
        // Heavier write traffic in the last phase
        b.io_wr = (phase == 3) ? (r[11:10] == 2'd0) : (r[13:10] == 4'd0);
        b.io_rd = !b.io_wr && r[14];
        b.wdata = r[31:16];
        bus <= b;
    endtask

    initial begin
        seed       = 32'h6779499c;
        stall_left = 0;
        pause_left = 0;
        reset_n    = 1'b0;
        bus        = '0;
        rom_ready  = 1'b1;
        vpulse     = 1'b0;
        pause_rq   = 1'b0;
        turbo      = 1'b0;
        board_cfg  = '0;
        players    = '0;
        dip_sw     = 24'd0;
        dma_busy   = 1'b0;
        snd_latch  = 8'd0;
        repeat (reset_cycles) @(posedge clk_sys);
        reset_n <= 1'b1;
        for (int cycle = 0; cycle < num_phases * phase_cycles; cycle++) begin
            @(posedge clk_sys);
            update_controls(cycle / phase_cycles);
            randomize_data_inputs();
            issue_bus_access(cycle / phase_cycles);
        end
        // The falling-edge check of the last cycle lies between these two edges
        repeat (2) @(posedge clk_sys);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    always @(posedge clk_sys) begin
        watchdog <= watchdog + 1;
        if (watchdog >= timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Something failed");
            $finish;
        end
    end

endmodule

// File: tb_m90_sys_checker.sv
/* Cycle-exact model of the system-control slice that compares on the falling edge.
   Model state follows the inputs as they stood before each rising edge. */
`timescale 1ns/1ps

module tb_m90_sys_checker (
    input  logic                            clk_sys,
    input  logic                            reset_n,
    input  m90_sys_pkg::cpu_bus_t           bus,
    input  logic                            rom_ready,
    input  logic                            vpulse,
    input  logic                            pause_rq,
    input  logic                            turbo,
    input  m90_sys_pkg::board_cfg_t         board_cfg,
    input  m90_sys_pkg::player_in_t         players,
    input  logic [23:0]                     dip_sw,
    input  logic                            dma_busy,
    input  logic [7:0]                      snd_latch,
    input  logic                            ce_1,
    input  logic                            ce_2,
    input  logic [m90_sys_pkg::timer_w-1:0] cycle_count,
    input  m90_sys_pkg::sys_flags_t         sys_flags,
    input  logic                            flip,
    input  logic [3:0]                      bank_select,
    input  logic                            sound_reset,
    input  logic [15:0]                     rdata,
    output int                              error_count,
    output int                              check_count
);

    localparam int cen_num_i = int'(m90_sys_pkg::cen_num);
    localparam int cen_den_i = int'(m90_sys_pkg::cen_den);
    localparam int defer_max = (1 << m90_sys_pkg::deferred_w) - 1;

    m90_sys_pkg::pause_state_t        m_state;
    int                               m_acc;
    int                               m_defer;
    logic                             m_toggle;
    logic                             m_ce1_q;
    logic                             m_ce2_q;
    logic [m90_sys_pkg::timer_w-1:0]  m_cycles;
    m90_sys_pkg::sys_flags_t          m_flags;
    logic [3:0]                       m_bank;
    logic                             m_sound_reset;
    logic                             m_paused;
    logic                             tick;
    logic                             step;
    logic                             exp_ce_1;
    logic                             exp_ce_2;

    assign m_paused = (m_state == m90_sys_pkg::paused);
    assign exp_ce_1 = m_ce1_q && rom_ready && !m_paused;
    assign exp_ce_2 = m_ce2_q && rom_ready && !m_paused;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    function automatic logic [7:0] switch_byte(input logic [9:0] p, input logic b5,
                                               input logic b4);
        return {p[4], p[5], b5, b4, p[3], p[2], p[1], p[0]};
    endfunction

    // Kick harness extra buttons 9 to 7 fill the top three bits of a nibble
    function automatic logic [3:0] extra_nibble(input logic [9:0] p);
        return {p[9], p[8], p[7], 1'b0};
    endfunction

    function automatic logic [15:0] expected_read();
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        logic [7:0] b4;
        if (board_cfg.kick_harness) begin
            b1 = switch_byte(players.p1, players.p1[6], 1'b0);
            b2 = switch_byte(players.p2, players.p2[6], 1'b0);
            b3 = 8'h00;
            b4 = {extra_nibble(players.p2), extra_nibble(players.p1)};
        end else begin
            b1 = switch_byte(players.p1, 1'b0, 1'b0);
            b2 = switch_byte(players.p2, 1'b0, 1'b0);
            b3 = switch_byte(players.p3, players.coin[2], players.start[2]);
            b4 = switch_byte(players.p4, players.coin[3], players.start[3]);
        end
        if (!bus.io_rd) return m90_sys_pkg::io_idle;
        case (bus.word_addr)
            m90_sys_pkg::io_p1_p2: return {~b2, ~b1};
            m90_sys_pkg::io_flags: return {~dip_sw[23:16], ~dma_busy, 3'b111,
                                           ~players.coin[1], ~players.coin[0],
                                           ~players.start[1], ~players.start[0]};
            m90_sys_pkg::io_dip:   return ~dip_sw[15:0];
            m90_sys_pkg::io_p3_p4: return {~b4, ~b3};
            m90_sys_pkg::io_latch: return {snd_latch, snd_latch};
            default:               return m90_sys_pkg::io_idle;
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("ERROR: t=%0t %s mismatch, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    always @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            m_state       <= m90_sys_pkg::run;
            m_acc         <= 0;
            m_defer       <= 0;
            m_toggle      <= 1'b0;
            m_ce1_q       <= 1'b0;
            m_ce2_q       <= 1'b0;
            m_cycles      <= '0;
            m_flags       <= '0;
            m_bank        <= 4'd0;
            m_sound_reset <= 1'b0;
        end else begin
            case (m_state)
                m90_sys_pkg::run: if (pause_rq) m_state <= m90_sys_pkg::wait_vbl;
                m90_sys_pkg::wait_vbl: begin
                    if (!pause_rq) m_state <= m90_sys_pkg::run;
                    else if (vpulse) m_state <= m90_sys_pkg::paused;
                end
                m90_sys_pkg::paused: if (!pause_rq && !vpulse) m_state <= m90_sys_pkg::run;
                default: m_state <= m90_sys_pkg::run;
            endcase

            tick = (m_acc + cen_num_i) >= cen_den_i;
            m_acc <= (m_acc + cen_num_i) % cen_den_i;
            if (tick && !rom_ready && m_defer < defer_max) m_defer <= m_defer + 1;
            else if (tick && rom_ready && m_defer > 0) m_defer <= m_defer - 1;

            step = !m_paused && (tick || turbo || (rom_ready && m_defer != 0));
            m_ce1_q <= step && m_toggle;
            m_ce2_q <= step && !m_toggle;
            if (step) m_toggle <= !m_toggle;
            if (exp_ce_1) m_cycles <= m_cycles + 1'b1;

            if (bus.io_wr && bus.word_addr == m90_sys_pkg::io_sys_flags) begin
                m_flags <= m90_sys_pkg::sys_flags_t'(bus.wdata[7:0]);
            end
            if (bus.io_wr && bus.word_addr == m90_sys_pkg::io_bank) m_bank <= bus.wdata[3:0];
            if (bus.io_wr && bus.word_addr == m90_sys_pkg::io_sound) begin
                m_sound_reset <= !bus.wdata[0];
            end
        end
    end

    always @(negedge clk_sys) begin
        if (reset_n) begin
            compare("ce_1", 32'(ce_1), 32'(exp_ce_1));
            compare("ce_2", 32'(ce_2), 32'(exp_ce_2));
            compare("cycle_count", 32'(cycle_count), 32'(m_cycles));
            compare("sys_flags", 32'(sys_flags), 32'(m_flags));
            compare("bank_select", 32'(bank_select), 32'(m_bank));
            compare("sound_reset", 32'(sound_reset), 32'(m_sound_reset));
            compare("flip", 32'(flip), 32'((~m_flags.soft_nl_n) ^ (~dip_sw[8])));
            compare("rdata", 32'(rdata), 32'(expected_read()));
        end
    end

endmodule
